/* dcache_sys.f */
common/dcache_pkg.sv
verilog/lfsr_way.sv
dcache/dcache_tags.sv
dcache/dcache_data.sv
dcache/dcache_ctrl.sv
verilog/dcache_top.sv
test/tb_clock.sv
test/mem_model.sv
test/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the data cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dcache_sys.f --top-module dcache_tb \
	-Mdir obj_dir -o dcache_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dcache_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* test/dcache_tb.sv */
/*
 * Testbench of the data cache subsystem
 * CPU stimulus, shadow byte memory as reference, response checks
 * Cycle limit and the closing result line
 */
`timescale 1ns/1ns

module dcache_tb;
	import dcache_pkg::*;

	localparam int PLANNED = 232;
	localparam int LIMIT = PLANNED * 200;

	logic clk;
	logic rst;
	logic dce;
	cpu_req_t cpu_req;
	cpu_resp_t cpu_resp;
	bus_req_t bus_req;
	bus_resp_t bus_resp;

	logic [7:0] shadow [16384];
	string cur_test;
	logic exp_err;
	logic exp_read;
	logic [31:0] exp_dat;
	logic [31:0] exp_adr;
	int checks = 0;
	int errors = 0;
	int test_base = 0;
	int cycles = 0;

	tb_clock #(.PERIOD(100)) tb_clock_inst (.clk_o(clk));

	dcache_top #(.WAYS(4), .SETS(16)) dcache_top_inst (
		.clk_i(clk), .rst_i(rst), .dce_i(dce), .cpu_req_i(cpu_req),
		.bus_resp_i(bus_resp), .cpu_resp_o(cpu_resp), .bus_req_o(bus_req)
	);

	mem_model mem_model_inst (
		.clk_i(clk), .rst_i(rst), .bus_req_i(bus_req), .bus_resp_o(bus_resp)
	);

	// ==================================================
	// Reference model
	// ==================================================

	// Same start pattern that the memory holds before any write
	function automatic logic [31:0] pattern_word(input logic [31:0] adr);
		logic [31:0] h;
		h = adr * 32'h9e3779b1;
		return h ^ (h >> 16) ^ 32'h5ac33ca5;
	endfunction

	function automatic logic in_err_range(input logic [31:0] adr);
		return adr[31:12] == 20'hfffff;
	endfunction

	// Little-endian word from the shadow bytes
	function automatic logic [31:0] expected_word(input logic [31:0] adr);
		int a;
		a = int'({adr[13:2], 2'b00});
		return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
	endfunction

	task automatic update_shadow(input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		int a;
		a = int'({adr[13:2], 2'b00});
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				shadow[a + b] = dat[b * 8 +: 8];
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	// One CPU access, held until ack or err, then cyc drops for a cycle
	task automatic access(input logic we, input logic nc, input logic en,
			input logic [31:0] adr, input logic [3:0] sel, input logic [31:0] dat);
		@(posedge clk);
		#1;
		exp_err = in_err_range(adr);
		exp_read = !we;
		exp_dat = expected_word(adr);
		exp_adr = adr;
		dce = en;
		cpu_req.cyc = 1'b1;
		cpu_req.we = we;
		cpu_req.nc = nc;
		cpu_req.adr.raw = adr;
		cpu_req.sel = sel;
		cpu_req.dat = dat;
		do
			@(negedge clk);
		while (!(cpu_resp.ack || cpu_resp.err));
		if (we && cpu_resp.ack)
			update_shadow(adr, sel, dat);
		@(posedge clk);
		#1;
		cpu_req.cyc = 1'b0;
		cpu_req.we = 1'b0;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_base = errors;
	endtask

	task automatic end_test();
		$display("Test %s finished with %0d errors", cur_test, errors - test_base);
	endtask

	// Responses are stable at the falling edge, hits answer combinationally
	always @(negedge clk) begin
		if (!rst && cpu_req.cyc && (cpu_resp.ack || cpu_resp.err)) begin
			checks++;
			assert (cpu_resp.err == exp_err) else begin
				$display("Error: %s at %h err expected %0d actual %0d",
					cur_test, exp_adr, exp_err, cpu_resp.err);
				errors++;
			end
			if (exp_read && !exp_err) begin
				checks++;
				assert (cpu_resp.dat == exp_dat) else begin
					$display("Error: %s at %h read expected %h actual %h",
						cur_test, exp_adr, exp_dat, cpu_resp.dat);
					errors++;
				end
			end
		end
	end

	// Limit follows the number of planned accesses
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT) begin
			$display("Timeout: no CPU response after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		logic [31:0] init_w;
		void'($urandom(32'h290b));
		rst = 1'b1;
		dce = 1'b1;
		cpu_req = '0;
		for (int a = 0; a < 16384; a += 4) begin
			init_w = pattern_word(32'(a));
			for (int b = 0; b < 4; b++)
				shadow[a + b] = init_w[b * 8 +: 8];
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		begin_test("read_miss_hit");
		access(1'b0, 1'b0, 1'b1, 32'h0100, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h0100, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h0114, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h0108, 4'hf, 32'h0);
		end_test();

		// Partial writes on a cached line, then a write miss that merges into the fill
		begin_test("write_merge");
		access(1'b1, 1'b0, 1'b1, 32'h0104, 4'b0011, 32'h11223344);
		access(1'b1, 1'b0, 1'b1, 32'h0118, 4'b1100, 32'h55667788);
		access(1'b1, 1'b0, 1'b1, 32'h010c, 4'b0101, 32'h99aabbcc);
		access(1'b1, 1'b0, 1'b1, 32'h0414, 4'b0110, 32'hdeadbeef);
		access(1'b0, 1'b0, 1'b1, 32'h0104, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h0118, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h010c, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h0414, 4'hf, 32'h0);
		end_test();

		// Five lines in set 3 against four ways
		begin_test("dirty_evict");
		for (int k = 0; k < 5; k++)
			access(1'b1, 1'b0, 1'b1, 32'h2064 + k * 32'h200, 4'hf, 32'hc0de0000 + k);
		for (int k = 0; k < 5; k++)
			access(1'b0, 1'b0, 1'b1, 32'h2064 + k * 32'h200, 4'hf, 32'h0);
		end_test();

		// Lines that are not cached, so the bypass and cached views agree
		begin_test("bypass");
		access(1'b1, 1'b1, 1'b1, 32'h3008, 4'hf, 32'h0badf00d);
		access(1'b0, 1'b1, 1'b1, 32'h3008, 4'hf, 32'h0);
		access(1'b1, 1'b0, 1'b0, 32'h3414, 4'b0110, 32'h12345678);
		access(1'b0, 1'b0, 1'b0, 32'h3414, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h3008, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h3414, 4'hf, 32'h0);
		end_test();

		// Small region so that hits, misses and evictions all occur
		begin_test("random");
		for (int n = 0; n < 200; n++)
			access(1'($urandom_range(1, 0)), 1'b0, 1'b1, 32'($urandom_range(1023, 0)) << 2,
				4'($urandom_range(15, 1)), $urandom);
		end_test();

		begin_test("error_range");
		access(1'b0, 1'b0, 1'b1, 32'hfffff010, 4'hf, 32'h0);
		access(1'b1, 1'b0, 1'b1, 32'hfffff820, 4'hf, 32'h77777777);
		access(1'b0, 1'b1, 1'b1, 32'hfffff004, 4'hf, 32'h0);
		access(1'b0, 1'b0, 1'b1, 32'h0100, 4'hf, 32'h0);
		end_test();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* test/mem_model.sv */
/*
 * Bus responder for the data cache testbench
 * 16 KB memory array with an address-based fill pattern
 * Random latency, injected retries and an error range in the top 4 KB
 */
`timescale 1ns/1ns

module mem_model (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  dcache_pkg::bus_req_t  bus_req_i,
	output dcache_pkg::bus_resp_t bus_resp_o
);
	import dcache_pkg::*;

	logic [BUS_W-1:0] mem [1024];
	logic [BUS_W-1:0] line;
	logic [9:0] beat_idx;
	logic busy;
	logic [1:0] delay;
	logic pulse;

	// Start value of a word, every address bit reaches the top bits
	function automatic logic [31:0] init_word(input logic [31:0] adr);
		logic [31:0] h;
		h = adr * 32'h9e3779b1;
		return h ^ (h >> 16) ^ 32'h5ac33ca5;
	endfunction

	assign beat_idx = bus_req_i.adr.raw[13:4];
	// The beat that was just answered is still on the bus for one cycle
	assign pulse = bus_resp_o.ack || bus_resp_o.rty || bus_resp_o.err;

	always @(posedge clk_i) begin
		bus_resp_o.ack <= 1'b0;
		bus_resp_o.rty <= 1'b0;
		bus_resp_o.err <= 1'b0;
		if (rst_i) begin
			busy <= 1'b0;
			delay <= 2'd0;
			bus_resp_o.dat <= '0;
			for (int i = 0; i < 1024; i++) begin
				for (int w = 0; w < 4; w++)
					mem[i][w * 32 +: 32] <= init_word(32'(i * 16 + w * 4));
			end
		end
		else if (bus_req_i.cyc && bus_req_i.stb && !pulse) begin
			if (!busy) begin
				// Accept the beat and pick how long it takes
				busy <= 1'b1;
				delay <= 2'($urandom_range(3, 0));
			end
			else if (delay != 2'd0) begin
				delay <= delay - 2'd1;
			end
			else begin
				busy <= 1'b0;
				if (bus_req_i.adr.raw[31:12] == 20'hfffff) begin
					bus_resp_o.err <= 1'b1;
				end
				else if ($urandom_range(7, 0) == 0) begin
					bus_resp_o.rty <= 1'b1;
				end
				else begin
					bus_resp_o.ack <= 1'b1;
					bus_resp_o.dat <= mem[beat_idx];
					if (bus_req_i.we) begin
						line = mem[beat_idx];
						for (int b = 0; b < 16; b++) begin
							if (bus_req_i.sel[b])
								line[b * 8 +: 8] = bus_req_i.dat[b * 8 +: 8];
						end
						mem[beat_idx] <= line;
					end
				end
			end
		end
	end

endmodule

/* test/tb_clock.sv */
/*
 * Clock generator for the data cache testbench
 * Free-running clock with a configurable period
 */
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk_o
);

	initial clk_o = 1'b0;

	// Half a period high, half a period low
	always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* verilog/dcache_top.sv */
/*
 * Top level of the data cache subsystem
 * Connects tag store, line storage, controller and LFSR
 */
`timescale 1ns/1ns

module dcache_top #(
	parameter int WAYS = 4,
	parameter int SETS = 16
) (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  dce_i,
	input  dcache_pkg::cpu_req_t  cpu_req_i,
	input  dcache_pkg::bus_resp_t bus_resp_i,
	output dcache_pkg::cpu_resp_t cpu_resp_o,
	output dcache_pkg::bus_req_t  bus_req_o
);
	import dcache_pkg::*;

	localparam int WAY_BITS = $clog2(WAYS);

	logic hit;
	logic [WAY_BITS-1:0] hit_way;
	// One way select serves victim readout, fills and hit accesses
	logic [WAY_BITS-1:0] way;
	logic [TAG_BITS-1:0] victim_tag;
	logic victim_dirty;
	logic tag_wr;
	logic dirty_set;
	logic fill_wr;
	logic [BUS_W-1:0] fill_dat;
	logic cpu_wr;
	logic [WORD_W-1:0] word;
	logic [BUS_W-1:0] half;
	logic [16:0] lfsr;

	// Lookups always use the CPU address
	dcache_tags #(
		.WAYS(WAYS),
		.SETS(SETS)
	) dcache_tags_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.lookup_adr_i(cpu_req_i.adr),
		.way_i(way),
		.tag_wr_i(tag_wr),
		.dirty_set_i(dirty_set),
		.dirty_way_i(way),
		.hit_o(hit),
		.hit_way_o(hit_way),
		.victim_tag_o(victim_tag),
		.victim_dirty_o(victim_dirty)
	);

	// The data array follows the bus address, which is the CPU address when idle
	dcache_data #(
		.WAYS(WAYS),
		.SETS(SETS)
	) dcache_data_inst (
		.clk_i(clk_i),
		.adr_i(bus_req_o.adr),
		.rd_way_i(way),
		.wr_way_i(way),
		.fill_wr_i(fill_wr),
		.fill_dat_i(fill_dat),
		.cpu_wr_i(cpu_wr),
		.cpu_sel_i(cpu_req_i.sel),
		.cpu_dat_i(cpu_req_i.dat),
		.word_o(word),
		.half_o(half)
	);

	dcache_ctrl #(
		.WAYS(WAYS),
		.SETS(SETS)
	) dcache_ctrl_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dce_i(dce_i),
		.cpu_req_i(cpu_req_i),
		.bus_resp_i(bus_resp_i),
		.hit_i(hit),
		.hit_way_i(hit_way),
		.victim_tag_i(victim_tag),
		.victim_dirty_i(victim_dirty),
		.half_i(half),
		.word_i(word),
		.lfsr_i(lfsr),
		.cpu_resp_o(cpu_resp_o),
		.bus_req_o(bus_req_o),
		.way_o(way),
		.tag_wr_o(tag_wr),
		.fill_wr_o(fill_wr),
		.fill_dat_o(fill_dat),
		.cpu_wr_o(cpu_wr),
		.dirty_set_o(dirty_set)
	);

	lfsr_way lfsr_way_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.lfsr_o(lfsr)
	);

endmodule

/* dcache/dcache_ctrl.sv */
/*
 * Request controller of the data cache
 * Hit response, miss with writeback and line load, bypass access
 * Retry backoff and error abort
 * Fill data merging and CPU response muxing
 */
`timescale 1ns/1ns

module dcache_ctrl #(
	parameter int WAYS = 4,
	parameter int SETS = 16
) (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  logic                            dce_i,
	input  dcache_pkg::cpu_req_t            cpu_req_i,
	input  dcache_pkg::bus_resp_t           bus_resp_i,
	input  logic                            hit_i,
	input  logic [$clog2(WAYS)-1:0]         hit_way_i,
	input  logic [dcache_pkg::TAG_BITS-1:0] victim_tag_i,
	input  logic                            victim_dirty_i,
	input  logic [dcache_pkg::BUS_W-1:0]    half_i,
	input  logic [dcache_pkg::WORD_W-1:0]   word_i,
	input  logic [16:0]                     lfsr_i,
	output dcache_pkg::cpu_resp_t           cpu_resp_o,
	output dcache_pkg::bus_req_t            bus_req_o,
	output logic [$clog2(WAYS)-1:0]         way_o,
	output logic                            tag_wr_o,
	output logic                            fill_wr_o,
	output logic [dcache_pkg::BUS_W-1:0]    fill_dat_o,
	output logic                            cpu_wr_o,
	output logic                            dirty_set_o
);
	import dcache_pkg::*;

	localparam int WAY_BITS = $clog2(WAYS);
	localparam int IDX_BITS = $clog2(SETS);
	localparam int IDX_LO = OFS_BITS + 1;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WB,
		ST_LOAD,
		ST_WAIT,
		ST_BACKOFF,
		ST_BYP
	} state_t;

	state_t state_q;
	// Where the wait and backoff states continue
	state_t ret_q;
	logic half_q;
	logic [1:0] got_q;
	logic [WAY_BITS-1:0] vway_q;
	logic resp_ack_q;
	logic resp_err_q;
	logic [WORD_W-1:0] resp_dat_q;

	logic cached;
	logic beat;
	logic own_half;
	logic last_half;
	logic [1:0] word_sel;
	logic [WORD_W-1:0] fill_word;
	dcache_addr_u wb_adr;
	dcache_addr_u ld_adr;

	// With the cache disabled every request goes straight to the bus
	assign cached = dce_i && !cpu_req_i.nc;
	assign word_sel = cpu_req_i.adr.f.offset[3:2];
	assign beat = state_q == ST_WB || state_q == ST_LOAD || state_q == ST_BYP;

	// The beat in flight carries the half that the CPU addressed
	assign own_half = half_q == cpu_req_i.adr.f.half;
	// True when this beat completes the line
	assign last_half = (got_q | (2'b01 << half_q)) == 2'b11;

	// ==================================================
	// Bus request
	// ==================================================

	// Victim line address, the set is shared with the CPU address
	assign wb_adr.raw = {victim_tag_i, cpu_req_i.adr.raw[IDX_LO +: IDX_BITS], half_q,
		{OFS_BITS{1'b0}}};

	always_comb begin
		ld_adr = cpu_req_i.adr;
		ld_adr.f.half = half_q;
		ld_adr.f.offset = '0;
	end

	// Built from state so that cyc, stb and we are low straight out of reset.
	// The address also steers the data array, hence the CPU address when idle
	always_comb begin
		bus_req_o.cyc = beat;
		bus_req_o.stb = beat;
		bus_req_o.we = state_q == ST_WB || (state_q == ST_BYP && cpu_req_i.we);
		bus_req_o.adr = ld_adr;
		bus_req_o.sel = 16'hffff;
		bus_req_o.dat = half_i;
		if (state_q == ST_WB)
			bus_req_o.adr = wb_adr;
		if (state_q == ST_IDLE || state_q == ST_BYP)
			bus_req_o.adr = cpu_req_i.adr;
		// A bypass moves one word in its byte lanes
		if (state_q == ST_BYP) begin
			bus_req_o.sel = 16'(cpu_req_i.sel) << {word_sel, 2'b00};
			bus_req_o.dat = {4{cpu_req_i.dat}};
		end
	end

	// ==================================================
	// Array strobes
	// ==================================================

	// Write miss bytes go into the beat that holds their half
	always_comb begin
		fill_dat_o = bus_resp_i.dat;
		if (cpu_req_i.we && own_half) begin
			for (int b = 0; b < 4; b++) begin
				if (cpu_req_i.sel[b])
					fill_dat_o[{word_sel, 5'd0} + b * 8 +: 8] = cpu_req_i.dat[b * 8 +: 8];
			end
		end
	end

	assign fill_word = fill_dat_o[{word_sel, 5'd0} +: WORD_W];

	assign fill_wr_o = state_q == ST_LOAD && bus_resp_i.ack;
	assign tag_wr_o = fill_wr_o && last_half;
	assign cpu_wr_o = state_q == ST_IDLE && cpu_req_i.cyc && cached && hit_i && cpu_req_i.we;
	// A write miss leaves its new line dirty
	assign dirty_set_o = cpu_wr_o || (tag_wr_o && cpu_req_i.we);

	// Hits use the matching way, a miss sticks to its victim
	assign way_o = state_q == ST_IDLE ? hit_way_i : vway_q;

	// Hits answer combinationally, everything else from the response registers
	always_comb begin
		if (state_q == ST_IDLE) begin
			cpu_resp_o.ack = cpu_req_i.cyc && cached && hit_i;
			cpu_resp_o.err = 1'b0;
			cpu_resp_o.dat = word_i;
		end
		else begin
			cpu_resp_o.ack = resp_ack_q;
			cpu_resp_o.err = resp_err_q;
			cpu_resp_o.dat = resp_dat_q;
		end
	end

	// ==================================================
	// Request FSM
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			ret_q <= ST_IDLE;
			half_q <= 1'b0;
			got_q <= 2'b00;
			vway_q <= '0;
			resp_ack_q <= 1'b0;
			resp_err_q <= 1'b0;
		end
		else begin
			// CPU ack and err are single-cycle pulses
			resp_ack_q <= 1'b0;
			resp_err_q <= 1'b0;
			case (state_q)
			ST_IDLE: begin
				if (cpu_req_i.cyc && !cached) begin
					state_q <= ST_BYP;
				end
				else if (cpu_req_i.cyc && !hit_i) begin
					// Victim chosen now, its dirty state is checked in the wait state
					vway_q <= lfsr_i[WAY_BITS-1:0];
					half_q <= 1'b0;
					got_q <= 2'b00;
					ret_q <= ST_WB;
					state_q <= ST_WAIT;
				end
			end
			ST_WB, ST_LOAD, ST_BYP: begin
				if (bus_resp_i.ack) begin
					state_q <= ST_WAIT;
					if (state_q == ST_WB) begin
						half_q <= ~half_q;
						ret_q <= half_q ? ST_LOAD : ST_WB;
					end
					else if (state_q == ST_LOAD) begin
						got_q[half_q] <= 1'b1;
						half_q <= ~half_q;
						if (own_half)
							resp_dat_q <= fill_word;
						resp_ack_q <= last_half;
						ret_q <= last_half ? ST_IDLE : ST_LOAD;
					end
					else begin
						resp_ack_q <= 1'b1;
						resp_dat_q <= bus_resp_i.dat[{word_sel, 5'd0} +: WORD_W];
						ret_q <= ST_IDLE;
					end
				end
				else if (bus_resp_i.rty) begin
					// Same beat again after the backoff
					ret_q <= state_q;
					state_q <= ST_BACKOFF;
				end
				else if (bus_resp_i.err) begin
					// Abandon the access, the tags stay untouched
					resp_err_q <= 1'b1;
					ret_q <= ST_IDLE;
					state_q <= ST_WAIT;
				end
			end
			ST_WAIT: begin
				// A clean victim skips the writeback altogether
				if (ret_q == ST_WB && !victim_dirty_i)
					state_q <= ST_LOAD;
				else
					state_q <= ret_q;
			end
			ST_BACKOFF: begin
				// Leaves on average after eight cycles
				if (lfsr_i[6:4] == 3'b111)
					state_q <= ret_q;
			end
			default: begin
				state_q <= ST_IDLE;
			end
			endcase
		end
	end

endmodule

/* dcache/dcache_data.sv */
/*
 * Line storage of the data cache
 * Word readout for the CPU, half-line readout for writebacks
 * Half-line fills and byte-enabled CPU writes
 */
`timescale 1ns/1ns

module dcache_data #(
	parameter int WAYS = 4,
	parameter int SETS = 16
) (
	input  logic                          clk_i,
	input  dcache_pkg::dcache_addr_u      adr_i,
	input  logic [$clog2(WAYS)-1:0]       rd_way_i,
	input  logic [$clog2(WAYS)-1:0]       wr_way_i,
	input  logic                          fill_wr_i,
	input  logic [dcache_pkg::BUS_W-1:0]  fill_dat_i,
	input  logic                          cpu_wr_i,
	input  logic [3:0]                    cpu_sel_i,
	input  logic [dcache_pkg::WORD_W-1:0] cpu_dat_i,
	output logic [dcache_pkg::WORD_W-1:0] word_o,
	output logic [dcache_pkg::BUS_W-1:0]  half_o
);
	import dcache_pkg::*;

	logic [LINE_W-1:0] line_q [WAYS][SETS];
	logic [SET_BITS-1:0] idx;
	logic [LINE_W-1:0] rd_line;
	logic [7:0] half_base;
	logic [7:0] word_base;

	assign idx = adr_i.f.index;

	// Bit positions of the addressed half and of the addressed word in the line
	assign half_base = {adr_i.f.half, 7'd0};
	assign word_base = {adr_i.f.half, adr_i.f.offset[3:2], 5'd0};

	// Readout is asynchronous, the controller answers hits in the same cycle
	assign rd_line = line_q[rd_way_i][idx];
	assign half_o = rd_line[half_base +: BUS_W];
	assign word_o = rd_line[word_base +: WORD_W];

	// A fill replaces one half, a CPU write touches only the selected bytes
	always_ff @(posedge clk_i) begin
		if (fill_wr_i)
			line_q[wr_way_i][idx][half_base +: BUS_W] <= fill_dat_i;
		if (cpu_wr_i) begin
			for (int b = 0; b < 4; b++) begin
				if (cpu_sel_i[b])
					line_q[wr_way_i][idx][word_base + b * 8 +: 8] <= cpu_dat_i[b * 8 +: 8];
			end
		end
	end

endmodule

/* dcache/dcache_tags.sv */
/*
 * Tag store of the data cache
 * Tag, valid and dirty arrays for every way
 * Combinational hit detection and victim readout
 */
`timescale 1ns/1ns

module dcache_tags #(
	parameter int WAYS = 4,
	parameter int SETS = 16
) (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  dcache_pkg::dcache_addr_u        lookup_adr_i,
	input  logic [$clog2(WAYS)-1:0]         way_i,
	input  logic                            tag_wr_i,
	input  logic                            dirty_set_i,
	input  logic [$clog2(WAYS)-1:0]         dirty_way_i,
	output logic                            hit_o,
	output logic [$clog2(WAYS)-1:0]         hit_way_o,
	output logic [dcache_pkg::TAG_BITS-1:0] victim_tag_o,
	output logic                            victim_dirty_o
);
	import dcache_pkg::*;

	localparam int WAY_BITS = $clog2(WAYS);

	logic [TAG_BITS-1:0] tag_q [WAYS][SETS];
	logic [WAYS-1:0][SETS-1:0] valid_q;
	logic [WAYS-1:0][SETS-1:0] dirty_q;
	logic [SET_BITS-1:0] idx;

	// Every port works on the set that the CPU address selects
	assign idx = lookup_adr_i.f.index;

	// Compare all ways at once so that a hit costs no extra cycle
	always_comb begin
		hit_o = 1'b0;
		hit_way_o = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid_q[w][idx] && tag_q[w][idx] == lookup_adr_i.f.tag) begin
				hit_o = 1'b1;
				hit_way_o = WAY_BITS'(w);
			end
		end
	end

	// Only a valid and dirty line needs to go back to memory
	assign victim_tag_o = tag_q[way_i][idx];
	assign victim_dirty_o = valid_q[way_i][idx] && dirty_q[way_i][idx];

	// Tag write at the end of a line load
	always_ff @(posedge clk_i) begin
		if (tag_wr_i)
			tag_q[way_i][idx] <= lookup_adr_i.f.tag;
	end

	// ==================================================
	// Line state
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else begin
			// A freshly loaded line starts out clean
			if (tag_wr_i) begin
				valid_q[way_i][idx] <= 1'b1;
				dirty_q[way_i][idx] <= 1'b0;
			end
			// Comes after the install so that a write miss leaves its line dirty
			if (dirty_set_i)
				dirty_q[dirty_way_i][idx] <= 1'b1;
		end
	end

endmodule

/* verilog/lfsr_way.sv */
/*
 * Free-running 17-bit LFSR
 * Random source for victim ways and retry backoff
 */
`timescale 1ns/1ns

module lfsr_way (
	input  logic        clk_i,
	input  logic        rst_i,
	output logic [16:0] lfsr_o
);

	// Fibonacci form of x^17 + x^14 + 1, which runs through all non-zero states
	always_ff @(posedge clk_i) begin
		if (rst_i)
			lfsr_o <= 17'h00001;
		else
			lfsr_o <= {lfsr_o[15:0], lfsr_o[16] ^ lfsr_o[13]};
	end

endmodule

/* common/dcache_pkg.sv */
/*
 * Shared definitions for the data cache subsystem
 * Address, line, bus and word widths
 * Address union with a raw view and a field view
 * CPU and bus request and response structs
 */
package dcache_pkg;

	// ==================================================
	// Widths
	// ==================================================

	localparam int ADDR_W = 32;
	localparam int LINE_W = 256;
	localparam int BUS_W = 128;
	localparam int WORD_W = 32;

	// Sixteen sets, each line split in two bus-wide halves
	localparam int SET_BITS = 4;
	localparam int OFS_BITS = 4;
	localparam int TAG_BITS = ADDR_W - SET_BITS - 1 - OFS_BITS;

	// ==================================================
	// Address word
	// ==================================================

	// Offset addresses a byte inside one 128-bit half
	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [SET_BITS-1:0] index;
		logic                half;
		logic [OFS_BITS-1:0] offset;
	} dcache_addr_fields_t;

	// The same address, either as plain bits for the bus or split for the arrays
	typedef union packed {
		logic [ADDR_W-1:0]   raw;
		dcache_addr_fields_t f;
	} dcache_addr_u;

	// ==================================================
	// Requests and responses
	// ==================================================

	// The CPU holds all of these steady until it sees ack or err
	typedef struct packed {
		logic              cyc;
		logic              we;
		logic              nc;
		dcache_addr_u      adr;
		logic [3:0]        sel;
		logic [WORD_W-1:0] dat;
	} cpu_req_t;

	typedef struct packed {
		logic              ack;
		logic              err;
		logic [WORD_W-1:0] dat;
	} cpu_resp_t;

	// One 128-bit beat per request, sel has one bit per byte lane
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		dcache_addr_u     adr;
		logic [15:0]      sel;
		logic [BUS_W-1:0] dat;
	} bus_req_t;

	// Ack, rty and err arrive as one-cycle pulses
	typedef struct packed {
		logic             ack;
		logic             rty;
		logic             err;
		logic [BUS_W-1:0] dat;
	} bus_resp_t;

endpackage
